// File: verilog/sdi_pkg.sv
package sdi_pkg;

	// Native debugger command codes
	typedef enum logic [7:0] {
		CMD_DEACT = 8'h00,
		CMD_AC    = 8'h41,
		CMD_BE    = 8'h42,
		CMD_ID    = 8'h49,
		CMD_NP    = 8'h4e,
		CMD_RR    = 8'h52,
		CMD_SE    = 8'h53,
		CMD_RW    = 8'h57
	} cmd_code_t;

	// Commands to the core debug unit
	typedef enum logic [3:0] {
		CORE_READ_REG   = 4'h0,
		CORE_WRITE_REG  = 4'h1,
		CORE_GO         = 4'h8,
		CORE_SINGLESTEP = 4'ha
	} core_cmd_t;

	// Returned by the ID command
	localparam logic [31:0] DEBUGGER_ID = 32'h5344_4931;

	// First byte of a UART response frame
	localparam logic [7:0] STATUS_OK    = 8'h00;
	localparam logic [7:0] STATUS_ERROR = 8'h01;

endpackage

// File: verilog/sdi_uart_receiver.sv
`timescale 1ns/100ps
`default_nettype none

module sdi_uart_receiver #(
	parameter int CLOCKS_PER_BIT = 4
)(
	input  wire logic       iCLOCK,
	input  wire logic       inRESET,
	input  wire logic       rxd,
	output logic            byte_valid,
	output logic [7:0]      byte_data
);

	localparam int CW = $clog2(CLOCKS_PER_BIT + 1);
	localparam int HALF_LAST = (CLOCKS_PER_BIT / 2 > 0) ? CLOCKS_PER_BIT / 2 - 1 : 0;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t b_state;
	logic [1:0] b_sync;
	logic [CW-1:0] b_cnt;
	logic [2:0] b_bit;
	logic [7:0] b_shift;
	logic rx;

	// Two flop synchronizer
	assign rx = b_sync[1];
	assign byte_data = b_shift;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_sync <= 2'b11;
			b_state <= RX_IDLE;
			b_cnt <= '0;
			b_bit <= 3'd0;
			byte_valid <= 1'b0;
		end
		else begin
			b_sync <= {b_sync[0], rxd};
			byte_valid <= 1'b0;
			case (b_state)
				RX_IDLE: begin
					b_cnt <= '0;
					if (!rx) begin
						b_state <= RX_START;
					end
				end
				RX_START: begin
					// Recheck the start bit near its middle
					if (b_cnt == CW'(HALF_LAST)) begin
						b_cnt <= '0;
						b_bit <= 3'd0;
						b_state <= rx ? RX_IDLE : RX_DATA;
					end
					else begin
						b_cnt <= b_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (b_cnt == CW'(CLOCKS_PER_BIT - 1)) begin
						b_cnt <= '0;
						b_bit <= b_bit + 1'b1;
						if (b_bit == 3'd7) begin
							b_state <= RX_STOP;
						end
					end
					else begin
						b_cnt <= b_cnt + 1'b1;
					end
				end
				default: begin
					if (b_cnt == CW'(CLOCKS_PER_BIT - 1)) begin
						byte_valid <= rx;
						b_state <= RX_IDLE;
					end
					else begin
						b_cnt <= b_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge iCLOCK) begin
		if (b_state == RX_DATA && b_cnt == CW'(CLOCKS_PER_BIT - 1)) begin
			b_shift <= {rx, b_shift[7:1]};
		end
	end

endmodule

`default_nettype wire

// File: verilog/sdi_uart_transmitter.sv
`timescale 1ns/100ps
`default_nettype none

module sdi_uart_transmitter #(
	parameter int CLOCKS_PER_BIT = 4
)(
	input  wire logic       iCLOCK,
	input  wire logic       inRESET,
	input  wire logic       send,
	input  wire logic [7:0] send_data,
	output logic            tx_busy,
	output logic            txd
);

	localparam int CW = $clog2(CLOCKS_PER_BIT + 1);

	logic b_busy;
	logic [CW-1:0] b_cnt;
	logic [3:0] b_bit;
	logic [9:0] b_shift;
	logic load;
	logic bit_end;

	assign load = send && !b_busy;
	assign bit_end = b_busy && (b_cnt == CW'(CLOCKS_PER_BIT - 1));
	assign tx_busy = b_busy;
	// Line idles high
	assign txd = b_busy ? b_shift[0] : 1'b1;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_busy <= 1'b0;
			b_cnt <= '0;
			b_bit <= 4'd0;
		end
		else if (load) begin
			b_busy <= 1'b1;
			b_cnt <= '0;
			b_bit <= 4'd0;
		end
		else if (b_busy) begin
			if (bit_end) begin
				b_cnt <= '0;
				if (b_bit == 4'd9) begin
					b_busy <= 1'b0;
				end
				else begin
					b_bit <= b_bit + 1'b1;
				end
			end
			else begin
				b_cnt <= b_cnt + 1'b1;
			end
		end
	end

	// Stop, data, start
	always_ff @(posedge iCLOCK) begin
		if (load) begin
			b_shift <= {1'b1, send_data, 1'b0};
		end
		else if (bit_end) begin
			b_shift <= {1'b1, b_shift[9:1]};
		end
	end

endmodule

`default_nettype wire

// File: verilog/sdi_interface_control.sv
`timescale 1ns/100ps
`default_nettype none

module sdi_interface_control import sdi_pkg::*; (
	input  wire logic        iCLOCK,
	input  wire logic        inRESET,
	// Parallel host port
	input  wire logic        para_req,
	input  wire logic [7:0]  para_cmd,
	input  wire logic [31:0] para_data,
	input  wire logic        para_rsp_busy,
	output logic             para_busy,
	output logic             para_valid,
	output logic             para_error,
	output logic [31:0]      para_rsp_data,
	// UART bytes
	input  wire logic        rx_valid,
	input  wire logic [7:0]  rx_data,
	output logic             tx_send,
	output logic [7:0]       tx_data,
	input  wire logic        tx_busy,
	// Common interface
	output logic             com_req,
	output cmd_code_t        com_cmd,
	output logic [31:0]      com_data,
	input  wire logic        com_busy,
	input  wire logic        rsp_valid,
	input  wire logic        rsp_error,
	input  wire logic [31:0] rsp_data,
	output logic             rsp_stall
);

	logic [2:0] b_rx_cnt;
	logic b_uart_pend;
	cmd_code_t b_uart_cmd;
	logic [31:0] b_uart_data;
	logic b_outstanding;
	logic b_owner_uart;
	logic b_tx_active;
	logic b_tx_send;
	logic [2:0] b_tx_idx;
	logic [7:0] b_tx_status;
	logic [31:0] b_tx_word;
	logic com_accept;
	logic uart_pop;
	logic uart_rsp;

	// Parallel wins a tie
	assign com_req = !b_outstanding && (para_req || b_uart_pend);
	assign com_cmd = para_req ? cmd_code_t'(para_cmd) : b_uart_cmd;
	assign com_data = para_req ? para_data : b_uart_data;
	assign com_accept = com_req && !com_busy;
	assign uart_pop = com_accept && !para_req;
	assign uart_rsp = rsp_valid && b_owner_uart;

	assign para_busy = b_outstanding;
	assign para_valid = rsp_valid && !b_owner_uart;
	assign para_error = rsp_error;
	assign para_rsp_data = rsp_data;
	assign rsp_stall = b_owner_uart ? b_tx_active : para_rsp_busy;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_outstanding <= 1'b0;
			b_owner_uart <= 1'b0;
		end
		else if (com_accept) begin
			b_outstanding <= 1'b1;
			b_owner_uart <= !para_req;
		end
		else if (rsp_valid) begin
			b_outstanding <= 1'b0;
		end
	end

	// Command byte, then data LSB first
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_rx_cnt <= 3'd0;
			b_uart_pend <= 1'b0;
		end
		else if (uart_pop) begin
			b_uart_pend <= 1'b0;
		end
		else if (rx_valid && !b_uart_pend) begin
			if (b_rx_cnt == 3'd4) begin
				b_rx_cnt <= 3'd0;
				b_uart_pend <= 1'b1;
			end
			else begin
				b_rx_cnt <= b_rx_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (rx_valid && !b_uart_pend) begin
			if (b_rx_cnt == 3'd0) begin
				b_uart_cmd <= cmd_code_t'(rx_data);
			end
			else begin
				b_uart_data <= {rx_data, b_uart_data[31:8]};
			end
		end
	end

	// Five byte response frame
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_tx_active <= 1'b0;
			b_tx_send <= 1'b0;
			b_tx_idx <= 3'd0;
		end
		else if (uart_rsp) begin
			b_tx_active <= 1'b1;
			b_tx_idx <= 3'd0;
		end
		else if (b_tx_send) begin
			// Byte taken by the transmitter on this edge
			b_tx_send <= 1'b0;
			if (b_tx_idx == 3'd4) begin
				b_tx_active <= 1'b0;
			end
			else begin
				b_tx_idx <= b_tx_idx + 1'b1;
			end
		end
		else if (b_tx_active && !tx_busy) begin
			b_tx_send <= 1'b1;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (uart_rsp) begin
			b_tx_status <= rsp_error ? STATUS_ERROR : STATUS_OK;
			b_tx_word <= rsp_data;
		end
	end

	assign tx_send = b_tx_send;

	always_comb begin
		case (b_tx_idx)
			3'd0: tx_data = b_tx_status;
			3'd1: tx_data = b_tx_word[7:0];
			3'd2: tx_data = b_tx_word[15:8];
			3'd3: tx_data = b_tx_word[23:16];
			default: tx_data = b_tx_word[31:24];
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/sdi_debugger.sv
`timescale 1ns/100ps
`default_nettype none

module sdi_debugger import sdi_pkg::*; (
	input  wire logic        iCLOCK,
	input  wire logic        inRESET,
	// Common interface
	input  wire logic        com_req,
	input  wire cmd_code_t   com_cmd,
	input  wire logic [31:0] com_data,
	output logic             com_busy,
	input  wire logic        rsp_stall,
	output logic             rsp_valid,
	output logic             rsp_error,
	output logic [31:0]      rsp_data,
	// Core debug unit
	output logic             core_req,
	output core_cmd_t        core_cmd,
	output logic [7:0]       core_target,
	output logic [31:0]      core_data,
	input  wire logic        core_busy,
	input  wire logic        core_valid,
	input  wire logic        core_error,
	input  wire logic [31:0] core_rsp_data
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ACTIVE,
		ST_ISSUE,
		ST_WAIT,
		ST_RESP
	} state_t;

	state_t b_state;
	logic b_active;
	cmd_code_t b_cmd;
	logic [31:0] b_data;
	logic is_core;
	logic go_local;
	logic local_error;
	logic [31:0] local_data;
	logic local_active;

	assign com_busy = !(b_state == ST_IDLE || b_state == ST_ACTIVE);
	assign rsp_valid = (b_state == ST_RESP) && !rsp_stall;

	assign is_core = (b_cmd == CMD_RR) || (b_cmd == CMD_RW) ||
		(b_cmd == CMD_SE) || (b_cmd == CMD_BE);
	// Anything not forwarded to the core is answered here
	assign go_local = (b_state == ST_ISSUE) && !(is_core && b_active);
	assign core_req = (b_state == ST_ISSUE) && is_core && b_active && !core_busy;

	always_comb begin
		local_error = 1'b1;
		local_data = 32'h0;
		local_active = b_active;
		case (b_cmd)
			CMD_AC: begin
				local_error = 1'b0;
				local_active = 1'b1;
			end
			CMD_DEACT: begin
				local_error = 1'b0;
				local_active = 1'b0;
			end
			CMD_ID: begin
				local_error = 1'b0;
				local_data = DEBUGGER_ID;
			end
			CMD_NP: local_error = !b_active;
			default: ;
		endcase
	end

	always_comb begin
		case (b_cmd)
			CMD_RW: core_cmd = CORE_WRITE_REG;
			CMD_SE: core_cmd = CORE_SINGLESTEP;
			CMD_BE: core_cmd = CORE_GO;
			default: core_cmd = CORE_READ_REG;
		endcase
	end

	assign core_target = (b_cmd == CMD_RR || b_cmd == CMD_RW) ? b_data[7:0] : 8'h00;
	// Write value sits above the register number
	assign core_data = (b_cmd == CMD_RW) ? {8'h00, b_data[31:8]} : 32'h0;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_state <= ST_IDLE;
			b_active <= 1'b0;
		end
		else begin
			case (b_state)
				ST_IDLE, ST_ACTIVE: begin
					if (com_req) begin
						b_state <= ST_ISSUE;
					end
				end
				ST_ISSUE: begin
					if (go_local) begin
						b_active <= local_active;
						b_state <= ST_RESP;
					end
					else if (!core_busy) begin
						b_state <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (core_valid) begin
						// Core fault drops out of debug mode
						if (core_error) begin
							b_active <= 1'b0;
						end
						b_state <= ST_RESP;
					end
				end
				ST_RESP: begin
					if (!rsp_stall) begin
						b_state <= b_active ? ST_ACTIVE : ST_IDLE;
					end
				end
				default: b_state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (com_req && !com_busy) begin
			b_cmd <= com_cmd;
			b_data <= com_data;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (go_local) begin
			rsp_error <= local_error;
			rsp_data <= local_data;
		end
		else if (b_state == ST_WAIT && core_valid) begin
			rsp_error <= core_error;
			rsp_data <= core_rsp_data;
		end
	end

endmodule

`default_nettype wire

// File: verilog/sdi_top.sv
`timescale 1ns/100ps
`default_nettype none

module sdi_top import sdi_pkg::*; #(
	parameter int CLOCKS_PER_BIT = 4
)(
	input  wire logic        iCLOCK,
	input  wire logic        inRESET,
	// Host UART
	input  wire logic        uart_rxd,
	output logic             uart_txd,
	// Host parallel port
	input  wire logic        para_req,
	input  wire logic [7:0]  para_cmd,
	input  wire logic [31:0] para_data,
	output logic             para_busy,
	output logic             para_valid,
	input  wire logic        para_rsp_busy,
	output logic             para_error,
	output logic [31:0]      para_rsp_data,
	// Core debug unit
	output logic             core_req,
	output core_cmd_t        core_cmd,
	output logic [7:0]       core_target,
	output logic [31:0]      core_data,
	input  wire logic        core_busy,
	input  wire logic        core_valid,
	input  wire logic        core_error,
	input  wire logic [31:0] core_rsp_data
);

	logic rx_valid;
	logic [7:0] rx_data;
	logic tx_send;
	logic [7:0] tx_data;
	logic tx_busy;
	logic com_req;
	cmd_code_t com_cmd;
	logic [31:0] com_data;
	logic com_busy;
	logic rsp_stall;
	logic rsp_valid;
	logic rsp_error;
	logic [31:0] rsp_data;

	sdi_uart_receiver #(
		.CLOCKS_PER_BIT(CLOCKS_PER_BIT)
	) u_rx (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.rxd(uart_rxd),
		.byte_valid(rx_valid),
		.byte_data(rx_data)
	);

	sdi_uart_transmitter #(
		.CLOCKS_PER_BIT(CLOCKS_PER_BIT)
	) u_tx (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.send(tx_send),
		.send_data(tx_data),
		.tx_busy(tx_busy),
		.txd(uart_txd)
	);

	sdi_interface_control u_if (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.para_req(para_req),
		.para_cmd(para_cmd),
		.para_data(para_data),
		.para_rsp_busy(para_rsp_busy),
		.para_busy(para_busy),
		.para_valid(para_valid),
		.para_error(para_error),
		.para_rsp_data(para_rsp_data),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.tx_send(tx_send),
		.tx_data(tx_data),
		.tx_busy(tx_busy),
		.com_req(com_req),
		.com_cmd(com_cmd),
		.com_data(com_data),
		.com_busy(com_busy),
		.rsp_valid(rsp_valid),
		.rsp_error(rsp_error),
		.rsp_data(rsp_data),
		.rsp_stall(rsp_stall)
	);

	sdi_debugger u_dbg (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.com_req(com_req),
		.com_cmd(com_cmd),
		.com_data(com_data),
		.com_busy(com_busy),
		.rsp_stall(rsp_stall),
		.rsp_valid(rsp_valid),
		.rsp_error(rsp_error),
		.rsp_data(rsp_data),
		.core_req(core_req),
		.core_cmd(core_cmd),
		.core_target(core_target),
		.core_data(core_data),
		.core_busy(core_busy),
		.core_valid(core_valid),
		.core_error(core_error),
		.core_rsp_data(core_rsp_data)
	);

endmodule

`default_nettype wire

// File: test/tb_sdi_top.sv
`timescale 1ns/100ps

module tb_sdi_top import sdi_pkg::*; ();

	localparam int CLOCKS_PER_BIT = 4;

	logic iCLOCK;
	logic inRESET;
	logic uart_rxd;
	logic uart_txd;
	logic para_req;
	logic [7:0] para_cmd;
	logic [31:0] para_data;
	logic para_busy;
	logic para_valid;
	logic para_rsp_busy;
	logic para_error;
	logic [31:0] para_rsp_data;
	logic core_req;
	core_cmd_t core_cmd;
	logic [7:0] core_target;
	logic [31:0] core_data;
	logic core_busy;
	logic core_valid;
	logic core_error;
	logic [31:0] core_rsp_data;

	integer seed;
	int cycle_cnt = 0;

	// Reference model state
	logic ref_active;
	logic [31:0] ref_mem [0:255];
	logic exp_err;
	logic [31:0] exp_data;
	logic exp_core;
	core_cmd_t exp_core_cmd;
	logic [7:0] exp_core_target;
	logic [31:0] exp_core_data;
	int exp_core_delay;

	// Core model state
	logic [31:0] core_mem [0:255];
	int core_req_count;
	int core_valid_cycle;

	logic [7:0] uart_status;
	logic [31:0] uart_word;

	sdi_top #(
		.CLOCKS_PER_BIT(CLOCKS_PER_BIT)
	) dut (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.uart_rxd(uart_rxd),
		.uart_txd(uart_txd),
		.para_req(para_req),
		.para_cmd(para_cmd),
		.para_data(para_data),
		.para_busy(para_busy),
		.para_valid(para_valid),
		.para_rsp_busy(para_rsp_busy),
		.para_error(para_error),
		.para_rsp_data(para_rsp_data),
		.core_req(core_req),
		.core_cmd(core_cmd),
		.core_target(core_target),
		.core_data(core_data),
		.core_busy(core_busy),
		.core_valid(core_valid),
		.core_error(core_error),
		.core_rsp_data(core_rsp_data)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #20 iCLOCK = ~iCLOCK;
	end

	always @(posedge iCLOCK) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_core_cmd(input string name, input core_cmd_t got, input core_cmd_t exp);
		if (got !== exp) begin
			fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
		end
	endtask

	function automatic logic [31:0] fill_word(input logic [7:0] a);
		return {~a, a ^ 8'h5a, a, a + 8'h33};
	endfunction

	function automatic logic [7:0] pick_cmd(input int n);
		case (n)
			0: return CMD_AC;
			1: return CMD_DEACT;
			2: return CMD_ID;
			3: return CMD_NP;
			4: return CMD_RR;
			5: return CMD_RW;
			6: return CMD_SE;
			7: return CMD_BE;
			default: return 8'h7a;
		endcase
	endfunction

	// Expected response from the command table
	task automatic predict(input logic [7:0] cmd, input logic [31:0] data);
		logic core_op;
		core_op = (cmd == CMD_RR) || (cmd == CMD_RW) || (cmd == CMD_SE) || (cmd == CMD_BE);
		exp_err = 1'b1;
		exp_data = 32'h0;
		exp_core = 1'b0;
		if (cmd == CMD_AC) begin
			exp_err = 1'b0;
			ref_active = 1'b1;
		end
		else if (cmd == CMD_DEACT) begin
			exp_err = 1'b0;
			ref_active = 1'b0;
		end
		else if (cmd == CMD_ID) begin
			exp_err = 1'b0;
			exp_data = DEBUGGER_ID;
		end
		else if (cmd == CMD_NP) begin
			exp_err = !ref_active;
		end
		else if (core_op && ref_active) begin
			exp_core = 1'b1;
			exp_core_target = (cmd == CMD_RR || cmd == CMD_RW) ? data[7:0] : 8'h00;
			exp_core_data = (cmd == CMD_RW) ? {8'h00, data[31:8]} : 32'h0;
			if (cmd == CMD_RR) exp_core_cmd = CORE_READ_REG;
			else if (cmd == CMD_RW) exp_core_cmd = CORE_WRITE_REG;
			else if (cmd == CMD_SE) exp_core_cmd = CORE_SINGLESTEP;
			else exp_core_cmd = CORE_GO;
			if (exp_core_target >= 8'hf0) begin
				ref_active = 1'b0;
			end
			else begin
				exp_err = 1'b0;
				if (cmd == CMD_RR) exp_data = ref_mem[exp_core_target];
				if (cmd == CMD_RW) ref_mem[exp_core_target] = exp_core_data;
			end
		end
	endtask

	// Core model, faults on targets F0h and up
	initial begin : core_model
		logic [7:0] tgt;
		core_cmd_t cmd;
		logic err;
		logic [31:0] rdata;
		int delay;
		core_busy = 1'b0;
		core_valid = 1'b0;
		core_error = 1'b0;
		core_rsp_data = 32'h0;
		core_req_count = 0;
		core_valid_cycle = 0;
		for (int i = 0; i < 256; i++) begin
			core_mem[8'(i)] = fill_word(8'(i));
		end
		forever begin
			@(negedge iCLOCK);
			if (inRESET && core_req) begin
				if (!exp_core) fail_now("Core request seen while none was expected");
				check_core_cmd("core_cmd", core_cmd, exp_core_cmd);
				check_byte("core_target", core_target, exp_core_target);
				check_word("core_data", core_data, exp_core_data);
				core_req_count++;
				tgt = core_target;
				cmd = core_cmd;
				delay = exp_core_delay;
				err = (tgt >= 8'hf0);
				rdata = 32'h0;
				if (!err && cmd == CORE_READ_REG) rdata = core_mem[tgt];
				if (!err && cmd == CORE_WRITE_REG) core_mem[tgt] = core_data;
				@(negedge iCLOCK);
				core_busy = 1'b1;
				repeat (delay - 1) @(negedge iCLOCK);
				core_valid = 1'b1;
				core_error = err;
				core_rsp_data = rdata;
				core_valid_cycle = cycle_cnt;
				@(negedge iCLOCK);
				core_valid = 1'b0;
				core_busy = 1'b0;
				core_error = 1'b0;
				core_rsp_data = 32'h0;
			end
		end
	end

	task automatic run_para_cmd(input logic [7:0] cmd, input logic [31:0] data, input bit stall);
		int t;
		int count;
		int stall_left;
		int req_before;
		bit done;
		predict(cmd, data);
		exp_core_delay = ({$random(seed)} % 4) + 1;
		req_before = core_req_count;
		stall_left = stall ? ({$random(seed)} % 12) + 1 : 0;
		t = 0;
		while (para_busy) begin
			@(negedge iCLOCK);
			t++;
			if (t > 100) fail_now("para_busy stuck high before a new command");
		end
		para_rsp_busy = (stall_left > 0);
		para_req = 1'b1;
		para_cmd = cmd;
		para_data = data;
		t = 0;
		@(negedge iCLOCK);
		while (!para_busy) begin
			t++;
			if (t > 100) fail_now("Parallel command was never accepted");
			@(negedge iCLOCK);
		end
		para_req = 1'b0;
		para_data = 32'h0;
		count = 0;
		done = 1'b0;
		// Response as the rising edge takes it
		while (!done) begin
			@(posedge iCLOCK);
			count++;
			if (count > 200) fail_now("No response on the parallel port");
			check_bit("para_busy", para_busy, 1'b1);
			if (para_valid) begin
				if (stall_left > 0) fail_now("Response presented while para_rsp_busy was high");
				check_bit("para_error", para_error, exp_err);
				check_word("para_rsp_data", para_rsp_data, exp_data);
				if (!stall && exp_core && cycle_cnt != core_valid_cycle + 1) begin
					fail_now("para_valid did not follow core_valid by one cycle");
				end
				if (!stall && !exp_core && count != 2) begin
					fail_now("Local response did not come 2 cycles after acceptance");
				end
				done = 1'b1;
			end
			@(negedge iCLOCK);
			if (stall_left > 0) begin
				stall_left--;
				para_rsp_busy = (stall_left > 0);
			end
		end
		// One response only, then the port is free
		check_bit("para_valid", para_valid, 1'b0);
		check_bit("para_busy", para_busy, 1'b0);
		if (core_req_count != req_before + (exp_core ? 1 : 0)) begin
			fail_now("Wrong number of core requests for the command");
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		logic [7:0] sh;
		sh = b;
		uart_rxd = 1'b0;
		repeat (CLOCKS_PER_BIT) @(negedge iCLOCK);
		repeat (8) begin
			uart_rxd = sh[0];
			sh = sh >> 1;
			repeat (CLOCKS_PER_BIT) @(negedge iCLOCK);
		end
		uart_rxd = 1'b1;
		repeat (CLOCKS_PER_BIT) @(negedge iCLOCK);
	endtask

	task automatic recv_byte(output logic [7:0] b);
		int t;
		logic [7:0] sh;
		t = 0;
		while (uart_txd) begin
			@(negedge iCLOCK);
			t++;
			if (t > 2000) fail_now("No start bit on uart_txd");
		end
		// Middle of the start bit
		repeat (CLOCKS_PER_BIT / 2) @(negedge iCLOCK);
		if (uart_txd) fail_now("Start bit on uart_txd too short");
		sh = 8'h00;
		repeat (8) begin
			repeat (CLOCKS_PER_BIT) @(negedge iCLOCK);
			sh = {uart_txd, sh[7:1]};
		end
		repeat (CLOCKS_PER_BIT) @(negedge iCLOCK);
		if (!uart_txd) fail_now("Missing stop bit on uart_txd");
		b = sh;
	endtask

	task automatic send_frame(input logic [7:0] cmd, input logic [31:0] data);
		logic [31:0] sh;
		sh = data;
		send_byte(cmd);
		repeat (4) begin
			send_byte(sh[7:0]);
			sh = sh >> 8;
		end
	endtask

	task automatic recv_frame();
		logic [7:0] b;
		recv_byte(uart_status);
		uart_word = 32'h0;
		repeat (4) begin
			recv_byte(b);
			uart_word = {b, uart_word[31:8]};
		end
	endtask

	task automatic run_uart_cmd(input logic [7:0] cmd, input logic [31:0] data);
		int req_before;
		predict(cmd, data);
		exp_core_delay = ({$random(seed)} % 4) + 1;
		req_before = core_req_count;
		@(negedge iCLOCK);
		fork
			send_frame(cmd, data);
			recv_frame();
		join
		check_byte("uart status", uart_status, exp_err ? STATUS_ERROR : STATUS_OK);
		check_word("uart data", uart_word, exp_data);
		if (core_req_count != req_before + (exp_core ? 1 : 0)) begin
			fail_now("Wrong number of core requests for the UART command");
		end
	endtask

	initial begin : stimulus
		logic [31:0] rnd;
		int n;
		seed = 24;
		inRESET = 1'b0;
		uart_rxd = 1'b1;
		para_req = 1'b0;
		para_cmd = 8'h00;
		para_data = 32'h0;
		para_rsp_busy = 1'b0;
		ref_active = 1'b0;
		exp_core = 1'b0;
		exp_core_delay = 1;
		for (int i = 0; i < 256; i++) begin
			ref_mem[8'(i)] = fill_word(8'(i));
		end
		repeat (8) @(negedge iCLOCK);
		inRESET = 1'b1;
		@(negedge iCLOCK);
		check_bit("para_busy", para_busy, 1'b0);
		check_bit("para_valid", para_valid, 1'b0);
		check_bit("core_req", core_req, 1'b0);
		check_bit("uart_txd", uart_txd, 1'b1);

		// Still inactive
		run_para_cmd(CMD_RR, 32'h0000_0003, 1'b0);
		run_para_cmd(CMD_NP, 32'h0, 1'b0);
		run_para_cmd(CMD_SE, 32'h0, 1'b0);

		run_para_cmd(CMD_ID, 32'h0, 1'b0);
		run_para_cmd(CMD_AC, 32'h0, 1'b0);
		run_para_cmd(CMD_NP, 32'h0, 1'b0);
		run_para_cmd(CMD_ID, 32'h0, 1'b0);
		run_para_cmd(CMD_DEACT, 32'h0, 1'b0);
		run_para_cmd(CMD_NP, 32'h0, 1'b0);
		run_para_cmd(CMD_AC, 32'h0, 1'b0);

		// Small register window so reads hit earlier writes
		repeat (40) begin
			rnd = $random(seed);
			run_para_cmd(rnd[0] ? CMD_RW : CMD_RR, {rnd[31:8], 4'h0, rnd[4:1]}, 1'b0);
		end

		rnd = $random(seed);
		run_para_cmd(CMD_SE, rnd, 1'b0);
		run_para_cmd(CMD_BE, rnd, 1'b0);
		run_para_cmd(CMD_RR, {rnd[31:8], 4'hf, rnd[3:0]}, 1'b0);
		run_para_cmd(CMD_NP, 32'h0, 1'b0);
		run_para_cmd(CMD_AC, 32'h0, 1'b0);

		// Host stalls the response port
		repeat (40) begin
			n = {$random(seed)} % 9;
			rnd = $random(seed);
			run_para_cmd(pick_cmd(n), rnd, 1'b1);
		end

		run_uart_cmd(CMD_AC, 32'h0);
		run_uart_cmd(CMD_RW, 32'h00ab_cd05);
		run_uart_cmd(CMD_RR, 32'h0000_0005);
		run_uart_cmd(CMD_ID, 32'h0);
		run_uart_cmd(8'h7a, 32'h1234_5678);
		repeat (4) begin
			n = {$random(seed)} % 9;
			rnd = $random(seed);
			run_uart_cmd(pick_cmd(n), rnd);
		end
		run_uart_cmd(CMD_DEACT, 32'h0);
		run_uart_cmd(CMD_NP, 32'h0);

		$display("sim passed");
		$finish;
	end

endmodule

// File: all.f
verilog/sdi_pkg.sv
verilog/sdi_uart_receiver.sv
verilog/sdi_uart_transmitter.sv
verilog/sdi_interface_control.sv
verilog/sdi_debugger.sv
verilog/sdi_top.sv
test/tb_sdi_top.sv

// File: Makefile
TOP := tb_sdi_top

.PHONY: all lint clean

all:
	verilator --binary --timing --timescale 1ns/100ps --top-module $(TOP) -f all.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "sim passed"

lint:
	verilator --lint-only -Wall --timescale 1ns/100ps --top-module sdi_top \
		verilog/sdi_pkg.sv \
		verilog/sdi_uart_receiver.sv \
		verilog/sdi_uart_transmitter.sv \
		verilog/sdi_interface_control.sv \
		verilog/sdi_debugger.sv \
		verilog/sdi_top.sv

clean:
	rm -rf obj_dir
